// ==== common/trace_pkg.sv ====
/*
 * Shared types for the trace monitor. Widths follow the OpenRISC core
 * (32-bit pc, instruction and data, 5-bit register index).
 */

`default_nettype none

package trace_pkg;

   // Major opcode of l.nop
   localparam logic [5:0] OPC_NOP = 6'h05;

   // Simulator codes carried in the l.nop immediate
   localparam logic [15:0] NOP_EXIT   = 16'h0001;
   localparam logic [15:0] NOP_REPORT = 16'h0002;
   localparam logic [15:0] NOP_PUTC   = 16'h0004;

   // l.nop layout: opcode, unused bits, 16-bit code
   typedef struct packed {
      logic [5:0]  opcode;
      logic [9:0]  rsvd;
      logic [15:0] code;
   } trace_nop_t;

   // Generic layout: opcode and the rest of the word
   typedef struct packed {
      logic [5:0]  opcode;
      logic [25:0] body;
   } trace_raw_t;

   // Same 32-bit word seen either as l.nop or as a plain opcode word
   typedef union packed {
      trace_nop_t nop;
      trace_raw_t raw;
   } trace_insn_u;

   // Kind of event record sent out of the monitor
   typedef enum logic [1:0] {
      EV_NONE   = 2'd0,
      EV_EXIT   = 2'd1,
      EV_REPORT = 2'd2,
      EV_PUTC   = 2'd3
   } event_kind_e;

endpackage

`default_nettype wire

// ==== trace_monitor/r3_shadow.sv ====
/*
 * Shadow copy of one core register, taken from the trace write-back.
 * Only sees writes that show up in the trace; holds zero after reset.
 */

`timescale 1ns/1ps
`default_nettype none

module r3_shadow #(
   parameter int WATCH_REG = 3
) (
   input  wire logic        clk_i,
   input  wire logic        rst_n_i,
   input  wire logic        trace_valid_i,
   input  wire logic        trace_wben_i,
   input  wire logic [4:0]  trace_wbreg_i,
   input  wire logic [31:0] trace_wbdata_i,
   output logic      [31:0] value_o
);

   logic [31:0] value_q;
   logic        hit;

   // Valid retired item writing the watched register
   assign hit = trace_valid_i && trace_wben_i && (trace_wbreg_i == 5'(WATCH_REG));

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         value_q <= '0;
      end else if (hit) begin
         value_q <= trace_wbdata_i;
      end
   end

   // Writes to other registers leave the copy untouched
   assign value_o = value_q;

endmodule

`default_nettype wire

// ==== trace_monitor/nop_decoder.sv ====
/*
 * Classifies retired instructions as simulator l.nop events.
 * One register stage; only event items are marked valid. Items are
 * dropped while halt_i is high.
 */

`timescale 1ns/1ps
`default_nettype none

module nop_decoder (
   input  wire logic                    clk_i,
   input  wire logic                    rst_n_i,
   input  wire logic                    halt_i,
   input  wire logic                    trace_valid_i,
   input  wire logic [31:0]             trace_pc_i,
   input  wire logic [31:0]             trace_insn_i,
   output logic                         dec_valid_o,
   output trace_pkg::event_kind_e       dec_kind_o,
   output logic      [31:0]             dec_pc_o
);

   trace_pkg::trace_insn_u insn;
   trace_pkg::event_kind_e kind_next;
   logic                   dec_valid_q;
   trace_pkg::event_kind_e dec_kind_q;
   logic [31:0]            dec_pc_q;

   assign insn = trace_insn_i;

   // Map the l.nop immediate to an event kind
   always_comb begin
      kind_next = trace_pkg::EV_NONE;
      if (insn.nop.opcode == trace_pkg::OPC_NOP) begin
         case (insn.nop.code)
            trace_pkg::NOP_EXIT:   kind_next = trace_pkg::EV_EXIT;
            trace_pkg::NOP_REPORT: kind_next = trace_pkg::EV_REPORT;
            trace_pkg::NOP_PUTC:   kind_next = trace_pkg::EV_PUTC;
            // Other codes are plain no-ops
            default:               kind_next = trace_pkg::EV_NONE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         dec_valid_q <= 1'b0;
      end else begin
         // Nothing passes once the monitor has halted
         dec_valid_q <= trace_valid_i && !halt_i && (kind_next != trace_pkg::EV_NONE);
      end
   end

   // Payload follows every valid item, qualified by dec_valid_q
   always_ff @(posedge clk_i) begin
      if (trace_valid_i) begin
         dec_kind_q <= kind_next;
         dec_pc_q   <= trace_pc_i;
      end
   end

   assign dec_valid_o = dec_valid_q;
   assign dec_kind_o  = dec_kind_q;
   assign dec_pc_o    = dec_pc_q;

endmodule

`default_nettype wire

// ==== trace_monitor/event_combiner.sv ====
/*
 * Merges decoded l.nop items with the register shadow and queues events.
 * FIFO holds FIFO_DEPTH entries; an event arriving while full is lost and
 * overflow_o sticks. terminated_o and exit_code_o clear only on reset.
 */

`timescale 1ns/1ps
`default_nettype none

module event_combiner #(
   parameter int FIFO_DEPTH = 4
) (
   input  wire logic                    clk_i,
   input  wire logic                    rst_n_i,
   input  wire logic                    dec_valid_i,
   input  wire trace_pkg::event_kind_e  dec_kind_i,
   input  wire logic [31:0]             dec_pc_i,
   input  wire logic [31:0]             shadow_i,
   output logic                         halt_o,
   output logic                         terminated_o,
   output logic      [31:0]             exit_code_o,
   output logic                         overflow_o,
   output logic                         event_valid_o,
   input  wire logic                    event_ready_i,
   output trace_pkg::event_kind_e       event_kind_o,
   output logic      [31:0]             event_pc_o,
   output logic      [31:0]             event_data_o
);

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   // Storage, one entry per queued event
   trace_pkg::event_kind_e kind_mem [FIFO_DEPTH];
   logic [31:0]            pc_mem   [FIFO_DEPTH];
   logic [31:0]            data_mem [FIFO_DEPTH];

   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;
   logic             full;
   logic             push;
   logic             pop;
   logic [31:0]      ev_data;
   logic             terminated_q;
   logic [31:0]      exit_code_q;
   logic             overflow_q;

   // putc only carries the character byte
   assign ev_data = (dec_kind_i == trace_pkg::EV_PUTC) ? {24'h0, shadow_i[7:0]} : shadow_i;

   assign full = (count_q == CNT_W'(FIFO_DEPTH));
   // Strictly full means dropped, even with a pop in the same cycle
   assign push = dec_valid_i && !full;
   assign pop  = event_valid_o && event_ready_i;

   always_ff @(posedge clk_i) begin
      if (push) begin
         kind_mem[wr_ptr_q] <= dec_kind_i;
         pc_mem[wr_ptr_q]   <= dec_pc_i;
         data_mem[wr_ptr_q] <= ev_data;
      end
   end

   // Circular pointers, wrapping explicitly for any depth
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         count_q <= '0;
      end else begin
         case ({push, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            // Both or neither keep the level
            default: count_q <= count_q;
         endcase
      end
   end

   // Sticky flags
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         overflow_q   <= 1'b0;
         terminated_q <= 1'b0;
         exit_code_q  <= '0;
      end else begin
         if (dec_valid_i && full) begin
            overflow_q <= 1'b1;
         end
         // First exit wins, code is r3 at that point
         if (dec_valid_i && (dec_kind_i == trace_pkg::EV_EXIT) && !terminated_q) begin
            terminated_q <= 1'b1;
            exit_code_q  <= shadow_i;
         end
      end
   end

   assign halt_o       = terminated_q;
   assign terminated_o = terminated_q;
   assign exit_code_o  = exit_code_q;
   assign overflow_o   = overflow_q;

   // Head of queue; stable until popped
   assign event_valid_o = (count_q != '0);
   assign event_kind_o  = kind_mem[rd_ptr_q];
   assign event_pc_o    = pc_mem[rd_ptr_q];
   assign event_data_o  = data_mem[rd_ptr_q];

endmodule

`default_nettype wire

// ==== verilog/trace_mon_top.sv ====
/*
 * Trace monitor for one core. Trace input has no handshake and can not
 * be stalled; back-pressure on the event output is absorbed by the FIFO.
 */

`timescale 1ns/1ps
`default_nettype none

module trace_mon_top #(
   parameter int FIFO_DEPTH = 4,
   parameter int WATCH_REG  = 3
) (
   input  wire logic                    clk_i,
   input  wire logic                    rst_n_i,
   input  wire logic                    trace_valid_i,
   input  wire logic [31:0]             trace_pc_i,
   input  wire logic [31:0]             trace_insn_i,
   input  wire logic                    trace_wben_i,
   input  wire logic [4:0]              trace_wbreg_i,
   input  wire logic [31:0]             trace_wbdata_i,
   output logic                         event_valid_o,
   input  wire logic                    event_ready_i,
   output trace_pkg::event_kind_e       event_kind_o,
   output logic      [31:0]             event_pc_o,
   output logic      [31:0]             event_data_o,
   output logic                         terminated_o,
   output logic      [31:0]             exit_code_o,
   output logic                         overflow_o
);

   logic [31:0]            shadow_value;
   logic                   dec_valid;
   trace_pkg::event_kind_e dec_kind;
   logic [31:0]            dec_pc;
   logic                   halt;

   // Shadow and decoder run side by side on the same trace cycle
   r3_shadow #(
      .WATCH_REG (WATCH_REG)
   ) u_shadow (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .trace_valid_i  (trace_valid_i),
      .trace_wben_i   (trace_wben_i),
      .trace_wbreg_i  (trace_wbreg_i),
      .trace_wbdata_i (trace_wbdata_i),
      .value_o        (shadow_value)
   );

   nop_decoder u_decoder (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .halt_i        (halt),
      .trace_valid_i (trace_valid_i),
      .trace_pc_i    (trace_pc_i),
      .trace_insn_i  (trace_insn_i),
      .dec_valid_o   (dec_valid),
      .dec_kind_o    (dec_kind),
      .dec_pc_o      (dec_pc)
   );

   // Combiner feeds halt back to stop decoding after exit
   event_combiner #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_combiner (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .dec_valid_i   (dec_valid),
      .dec_kind_i    (dec_kind),
      .dec_pc_i      (dec_pc),
      .shadow_i      (shadow_value),
      .halt_o        (halt),
      .terminated_o  (terminated_o),
      .exit_code_o   (exit_code_o),
      .overflow_o    (overflow_o),
      .event_valid_o (event_valid_o),
      .event_ready_i (event_ready_i),
      .event_kind_o  (event_kind_o),
      .event_pc_o    (event_pc_o),
      .event_data_o  (event_data_o)
   );

endmodule

`default_nettype wire

// ==== test/trace_mon_properties.sv ====
/*
 * Protocol checks on the event output, bound into trace_mon_top.
 * fail_count holds the number of failed assertions.
 */

`timescale 1ns/1ps
`default_nettype none

module trace_mon_properties (
   input wire logic                   clk_i,
   input wire logic                   rst_n_i,
   input wire logic                   event_valid_i,
   input wire logic                   event_ready_i,
   input wire trace_pkg::event_kind_e event_kind_i,
   input wire logic [31:0]            event_pc_i,
   input wire logic [31:0]            event_data_i,
   input wire logic                   terminated_i,
   input wire logic                   overflow_i
);

   int fail_count = 0;

   // Stalled event keeps valid and payload
   hold_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      event_valid_i && !event_ready_i |=> event_valid_i && $stable(event_kind_i)
         && $stable(event_pc_i) && $stable(event_data_i))
      else begin
         fail_count++;
         $error("event output changed while waiting for ready");
      end

   // Sticky flags fall only through reset
   term_sticky: assert property (@(posedge clk_i) terminated_i && rst_n_i |=> terminated_i)
      else begin
         fail_count++;
         $error("terminated flag fell without reset");
      end

   ovf_sticky: assert property (@(posedge clk_i) overflow_i && rst_n_i |=> overflow_i)
      else begin
         fail_count++;
         $error("overflow flag fell without reset");
      end

   // Queue is empty right after reset
   reset_idle: assert property (@(posedge clk_i) !rst_n_i |=> !event_valid_i)
      else begin
         fail_count++;
         $error("event valid high in the cycle after reset");
      end

endmodule

bind trace_mon_top trace_mon_properties u_props (
   .clk_i         (clk_i),
   .rst_n_i       (rst_n_i),
   .event_valid_i (event_valid_o),
   .event_ready_i (event_ready_i),
   .event_kind_i  (event_kind_o),
   .event_pc_i    (event_pc_o),
   .event_data_i  (event_data_o),
   .terminated_i  (terminated_o),
   .overflow_i    (overflow_o)
);

`default_nettype wire

// ==== test/tb_trace_mon.sv ====
/*
 * Testbench for the trace monitor top level. Expected events come from a
 * reference queue built from the l.nop rules; random data uses seed 74.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_trace_mon;

   localparam int FIFO_DEPTH = 4;
   localparam int WATCH_REG  = 3;
   localparam int WAIT_LIMIT = 60;

   logic                   clk;
   logic                   rst_n;
   logic                   trace_valid;
   logic [31:0]            trace_pc;
   logic [31:0]            trace_insn;
   logic                   trace_wben;
   logic [4:0]             trace_wbreg;
   logic [31:0]            trace_wbdata;
   logic                   event_valid;
   logic                   event_ready;
   trace_pkg::event_kind_e event_kind;
   logic [31:0]            event_pc;
   logic [31:0]            event_data;
   logic                   terminated;
   logic [31:0]            exit_code;
   logic                   overflow;

   // Reference queues with one entry per event that must come out
   trace_pkg::event_kind_e exp_kind_q [$];
   logic [31:0]            exp_pc_q   [$];
   logic [31:0]            exp_data_q [$];

   logic [31:0] model_r3;
   logic [31:0] next_pc;
   int          errors;
   int          tests_run;
   int          tests_failed;
   int          events_seen;
   int          test_start_fails;

   trace_mon_top #(
      .FIFO_DEPTH (FIFO_DEPTH),
      .WATCH_REG  (WATCH_REG)
   ) DUT (
      .clk_i          (clk),
      .rst_n_i        (rst_n),
      .trace_valid_i  (trace_valid),
      .trace_pc_i     (trace_pc),
      .trace_insn_i   (trace_insn),
      .trace_wben_i   (trace_wben),
      .trace_wbreg_i  (trace_wbreg),
      .trace_wbdata_i (trace_wbdata),
      .event_valid_o  (event_valid),
      .event_ready_i  (event_ready),
      .event_kind_o   (event_kind),
      .event_pc_o     (event_pc),
      .event_data_o   (event_data),
      .terminated_o   (terminated),
      .exit_code_o    (exit_code),
      .overflow_o     (overflow)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Simulator codes 1, 2 and 4 carry events and all others are plain no-ops
   function automatic trace_pkg::event_kind_e kind_of_code(input logic [15:0] code);
      case (code)
         trace_pkg::NOP_EXIT:   return trace_pkg::EV_EXIT;
         trace_pkg::NOP_REPORT: return trace_pkg::EV_REPORT;
         trace_pkg::NOP_PUTC:   return trace_pkg::EV_PUTC;
         default:               return trace_pkg::EV_NONE;
      endcase
   endfunction

   // Check errors plus failed protocol assertions
   function automatic int total_failures();
      return errors + DUT.u_props.fail_count;
   endfunction

   // Move to the next edge and 1 ns into the cycle where inputs change
   task automatic step();
      @(posedge clk);
      #1;
   endtask

   task automatic send_item(input logic [31:0] insn, input logic wben,
                            input logic [4:0] wbreg, input logic [31:0] wbdata);
      trace_valid  = 1'b1;
      trace_pc     = next_pc;
      trace_insn   = insn;
      trace_wben   = wben;
      trace_wbreg  = wbreg;
      trace_wbdata = wbdata;
      next_pc      = next_pc + 32'd4;
      step();
      trace_valid  = 1'b0;
      trace_wben   = 1'b0;
   endtask

   // l.addi style word with a register write-back
   task automatic write_reg(input logic [4:0] wbreg, input logic [31:0] data);
      trace_pkg::trace_insn_u w;
      w.raw.opcode = 6'h27;
      w.raw.body   = 26'($urandom);
      if (32'(wbreg) == WATCH_REG) begin
         model_r3 = data;
      end
      send_item(w, 1'b1, wbreg, data);
   endtask

   // deliver low means the event is expected to be lost
   task automatic send_nop(input logic [15:0] code, input bit deliver);
      trace_pkg::trace_insn_u w;
      trace_pkg::event_kind_e kind;
      w.nop.opcode = trace_pkg::OPC_NOP;
      w.nop.rsvd   = '0;
      w.nop.code   = code;
      kind         = kind_of_code(code);
      if (deliver && kind != trace_pkg::EV_NONE) begin
         exp_kind_q.push_back(kind);
         exp_pc_q.push_back(next_pc);
         // putc keeps only the character byte of r3
         exp_data_q.push_back(kind == trace_pkg::EV_PUTC ? {24'h0, model_r3[7:0]} : model_r3);
      end
      send_item(w, 1'b0, 5'd0, 32'h0);
   endtask

   task automatic check_event();
      trace_pkg::event_kind_e exp_kind;
      logic [31:0]            exp_pc;
      logic [31:0]            exp_data;
      events_seen++;
      if (exp_kind_q.size() == 0) begin
         $display("Event at pc %h came out although none was expected", event_pc);
         errors++;
      end else begin
         exp_kind = exp_kind_q.pop_front();
         exp_pc   = exp_pc_q.pop_front();
         exp_data = exp_data_q.pop_front();
         assert (event_kind == exp_kind) else begin
            $display("[FAIL] event_kind_o got %h expected %h", event_kind, exp_kind);
            errors++;
         end
         assert (event_pc == exp_pc) else begin
            $display("[FAIL] event_pc_o got %h expected %h", event_pc, exp_pc);
            errors++;
         end
         assert (event_data == exp_data) else begin
            $display("[FAIL] event_data_o got %h expected %h", event_data, exp_data);
            errors++;
         end
      end
   endtask

   // Transfers are sampled mid-cycle away from both edges
   initial begin
      forever begin
         @(negedge clk);
         if (rst_n && event_valid && event_ready) begin
            check_event();
         end
      end
   end

   task automatic wait_drain();
      int cycles;
      cycles = 0;
      while (exp_kind_q.size() != 0 && cycles < WAIT_LIMIT) begin
         step();
         cycles++;
      end
      if (exp_kind_q.size() != 0) begin
         $display("Timed out with %0d expected events still missing", exp_kind_q.size());
         errors++;
         exp_kind_q.delete();
         exp_pc_q.delete();
         exp_data_q.delete();
      end
   endtask

   // Select 1 waits for overflow_o and 0 for terminated_o
   task automatic wait_for_flag(input bit sel_overflow);
      int cycles;
      cycles = 0;
      while (!(sel_overflow ? overflow : terminated) && cycles < WAIT_LIMIT) begin
         step();
         cycles++;
      end
      if (!(sel_overflow ? overflow : terminated)) begin
         $display("Timed out waiting for %s to rise", sel_overflow ? "overflow" : "termination");
         errors++;
      end
   endtask

   // An event surfaces two edges after its item so four cycles is enough
   task automatic settle();
      repeat (4) step();
      assert (!event_valid) else begin
         $display("[FAIL] event_valid_o got %h expected %h", event_valid, 1'b0);
         errors++;
      end
   endtask

   task automatic finish_test(input string name);
      int now_fails;
      now_fails = total_failures();
      tests_run++;
      if (now_fails == test_start_fails) begin
         $display("Test %0d %s: passed", tests_run, name);
      end else begin
         tests_failed++;
         $display("Test %0d %s: failed with %0d errors", tests_run, name,
                  now_fails - test_start_fails);
      end
      test_start_fails = now_fails;
   endtask

   initial begin
      logic [4:0]             other_reg;
      trace_pkg::trace_insn_u w;
      void'($urandom(74));
      rst_n            = 1'b0;
      trace_valid      = 1'b0;
      trace_pc         = '0;
      trace_insn       = '0;
      trace_wben       = 1'b0;
      trace_wbreg      = '0;
      trace_wbdata     = '0;
      event_ready      = 1'b1;
      model_r3         = '0;
      next_pc          = 32'h0000_2000;
      errors           = 0;
      tests_run        = 0;
      tests_failed     = 0;
      events_seen      = 0;
      test_start_fails = 0;
      repeat (5) @(posedge clk);
      #1;
      rst_n = 1'b1;
      step();

      // Reset state
      assert (!event_valid) else begin
         $display("[FAIL] event_valid_o got %h expected %h", event_valid, 1'b0);
         errors++;
      end
      assert (!terminated) else begin
         $display("[FAIL] terminated_o got %h expected %h", terminated, 1'b0);
         errors++;
      end
      assert (!overflow) else begin
         $display("[FAIL] overflow_o got %h expected %h", overflow, 1'b0);
         errors++;
      end
      finish_test("reset state");

      // Report carries the last r3 write while other registers are ignored
      repeat (6) begin
         other_reg = 5'($urandom_range(31, 1));
         if (32'(other_reg) == WATCH_REG) begin
            other_reg = 5'd4;
         end
         write_reg(5'(WATCH_REG), $urandom);
         write_reg(other_reg, $urandom);
      end
      send_nop(trace_pkg::NOP_REPORT, 1'b1);
      // A write right after the nop must not leak into its event
      write_reg(5'(WATCH_REG), $urandom);
      wait_drain();
      settle();
      finish_test("report");

      // putc with high bits set in r3
      write_reg(5'(WATCH_REG), $urandom | 32'hFF00_0000);
      send_nop(trace_pkg::NOP_PUTC, 1'b1);
      wait_drain();
      settle();
      finish_test("putc");

      // Non-event words including a non-nop opcode with a report code
      write_reg(5'd7, $urandom);
      w.raw.opcode = 6'h27;
      w.raw.body   = {10'($urandom), trace_pkg::NOP_REPORT};
      send_item(w, 1'b0, 5'd0, 32'h0);
      send_nop(16'h0000, 1'b1);
      send_nop(16'h0010, 1'b1);
      settle();
      finish_test("no event");

      // Back-pressure where the last report finds the FIFO full
      event_ready = 1'b0;
      for (int i = 0; i <= FIFO_DEPTH; i++) begin
         write_reg(5'(WATCH_REG), $urandom);
         send_nop(trace_pkg::NOP_REPORT, i < FIFO_DEPTH);
      end
      wait_for_flag(1'b1);
      event_ready = 1'b1;
      wait_drain();
      settle();
      assert (overflow) else begin
         $display("[FAIL] overflow_o got %h expected %h", overflow, 1'b1);
         errors++;
      end
      finish_test("back-pressure");

      // Exit latches r3 and later reports are ignored
      write_reg(5'(WATCH_REG), $urandom);
      send_nop(trace_pkg::NOP_EXIT, 1'b1);
      wait_for_flag(1'b0);
      assert (exit_code == model_r3) else begin
         $display("[FAIL] exit_code_o got %h expected %h", exit_code, model_r3);
         errors++;
      end
      wait_drain();
      send_nop(trace_pkg::NOP_REPORT, 1'b0);
      settle();
      assert (terminated) else begin
         $display("[FAIL] terminated_o got %h expected %h", terminated, 1'b1);
         errors++;
      end
      finish_test("exit");

      $display("Tests %0d, failed %0d, events %0d, errors %0d, assertion failures %0d",
               tests_run, tests_failed, events_seen, errors, DUT.u_props.fail_count);
      if (total_failures() == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb.f ====
common/trace_pkg.sv
trace_monitor/r3_shadow.sv
trace_monitor/nop_decoder.sv
trace_monitor/event_combiner.sv
verilog/trace_mon_top.sv
test/trace_mon_properties.sv
test/tb_trace_mon.sv

// ==== Makefile ====
# Verilator build and run of the trace monitor testbench
TOP := tb_trace_mon
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f tb.f -o $(TOP) --Mdir obj_dir

# Error limit raised so the testbench summary still prints after a failed assertion
run: compile
	./obj_dir/$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	grep -q "^Everything OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
